/* design/stbuf_alloc.sv */
module stbuf_alloc #(
  parameter int NUM_ENTRIES = 4
) (
  input  logic                  i_st_valid,
  input  stbuf_pkg::st_req_t    i_st,
  input  stbuf_pkg::st_entry_t  i_entries [NUM_ENTRIES],
  input  logic [NUM_ENTRIES-1:0] i_ready_to_merge,

  output logic [NUM_ENTRIES-1:0] o_load,
  output logic [NUM_ENTRIES-1:0] o_merge,
  output stbuf_pkg::st_req_t    o_st_entry,
  output logic                  o_st_stall
);

  logic [NUM_ENTRIES-1:0] w_same_line;
  logic [NUM_ENTRIES-1:0] w_merge_hit;
  logic [NUM_ENTRIES-1:0] w_free;
  logic [NUM_ENTRIES-1:0] w_free_oh;
  logic                   w_blocked;
  logic                   w_any_merge;

  // ------------------------------
  // Line compare against entries
  // ------------------------------
  always_comb begin
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      w_same_line[e] = i_entries[e].valid & (i_entries[e].line == i_st.line);
      w_free[e]      = ~i_entries[e].valid;
    end
  end

  assign w_merge_hit = w_same_line & i_ready_to_merge;
  assign w_any_merge = |w_merge_hit;

  // Lowest free entry isolated from the free vector
  assign w_free_oh = w_free & (~w_free + 1'b1);

  // Same line already past the merge window
  assign w_blocked = |(w_same_line & ~i_ready_to_merge);

  // Stall only looks at the offered store, not its valid
  assign o_st_stall = w_blocked | (~w_any_merge & ~|w_free);

  assign o_merge = (i_st_valid & ~w_blocked) ? w_merge_hit : '0;
  assign o_load  = (i_st_valid & ~o_st_stall & ~w_any_merge) ? w_free_oh : '0;

  assign o_st_entry = i_st;

  // A store goes to exactly one place
  always_comb begin
    assert (!((|o_load) && (|o_merge)) && $onehot0(o_load) && $onehot0(o_merge))
      else $error("stbuf_alloc: load %b merge %b not exclusive", o_load, o_merge);
  end

endmodule

/* design/stbuf_entry.sv */
module stbuf_entry #(
  parameter int LSU_PORTS = 2
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  input  logic                  i_load,
  input  logic                  i_merge,
  input  stbuf_pkg::st_req_t    i_st,

  input  logic                  i_rd_accepted,
  input  logic                  i_rd_resp_vld,
  input  logic                  i_rd_hit,
  input  logic                  i_refill_accepted,
  input  logic                  i_refill_done,
  input  stbuf_pkg::line_addr_t i_refill_line,
  input  logic                  i_wr_accepted,

  input  logic [LSU_PORTS-1:0]  i_fwd_valid,
  input  stbuf_pkg::line_addr_t i_fwd_line [LSU_PORTS],

  output stbuf_pkg::st_entry_t  o_entry,
  output logic                  o_ready_to_merge,
  output logic                  o_rd_req,
  output logic                  o_refill_req,
  output logic                  o_wr_req,
  output logic [LSU_PORTS-1:0]  o_fwd_hit
);

  stbuf_pkg::st_state_t r_state;
  stbuf_pkg::st_state_t w_state_next;
  logic                 r_valid;
  stbuf_pkg::st_req_t   r_body;
  stbuf_pkg::st_req_t   w_merged;
  logic                 w_take_load;

  assign w_take_load = i_load & (r_state == stbuf_pkg::IDLE);

  // ------------------------------
  // Byte merge
  // ------------------------------
  always_comb begin
    w_merged = r_body;
    for (int b = 0; b < stbuf_pkg::ST_BYTES; b++) begin
      if (i_st.strb[b]) begin
        w_merged.data[b*8 +: 8] = i_st.data[b*8 +: 8];  // Newer byte wins
      end
    end
    w_merged.strb = r_body.strb | i_st.strb;
  end

  always_ff @(posedge i_clk) begin
    if (w_take_load) begin
      r_body <= i_st;
    end else if (i_merge) begin
      r_body <= w_merged;
    end
  end

  // ------------------------------
  // State machine
  // ------------------------------
  always_comb begin
    w_state_next = r_state;
    case (r_state)
      stbuf_pkg::IDLE: begin
        if (i_load) w_state_next = stbuf_pkg::RD_L1D;
      end
      stbuf_pkg::RD_L1D: begin
        if (i_rd_accepted) w_state_next = stbuf_pkg::RD_RESP;
      end
      stbuf_pkg::RD_RESP: begin
        if (i_rd_resp_vld) begin
          w_state_next = i_rd_hit ? stbuf_pkg::WR_L1D : stbuf_pkg::REFILL_REQ;
        end
      end
      stbuf_pkg::REFILL_REQ: begin
        if (i_refill_accepted) w_state_next = stbuf_pkg::WAIT_REFILL;
      end
      stbuf_pkg::WAIT_REFILL: begin
        // Replay the tag read once our line is in
        if (i_refill_done && (i_refill_line == r_body.line)) begin
          w_state_next = stbuf_pkg::RD_L1D;
        end
      end
      stbuf_pkg::WR_L1D: begin
        if (i_wr_accepted) w_state_next = stbuf_pkg::FINISH;
      end
      stbuf_pkg::FINISH: w_state_next = stbuf_pkg::IDLE;
      default:           w_state_next = stbuf_pkg::IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= stbuf_pkg::IDLE;
      r_valid <= 1'b0;
    end else begin
      r_state <= w_state_next;
      if (w_take_load) begin
        r_valid <= 1'b1;
      end else if (r_state == stbuf_pkg::FINISH) begin
        r_valid <= 1'b0;  // Free again from next cycle
      end
    end
  end

  // ------------------------------
  // Outputs
  // ------------------------------
  always_comb begin
    o_entry.valid = r_valid;
    o_entry.line  = r_body.line;
    o_entry.data  = r_body.data;
    o_entry.strb  = r_body.strb;
  end

  assign o_ready_to_merge = r_valid & ((r_state == stbuf_pkg::RD_L1D) |
                                       (r_state == stbuf_pkg::RD_RESP) |
                                       (r_state == stbuf_pkg::REFILL_REQ) |
                                       (r_state == stbuf_pkg::WAIT_REFILL));

  assign o_rd_req     = r_valid & (r_state == stbuf_pkg::RD_L1D);
  assign o_refill_req = r_valid & (r_state == stbuf_pkg::REFILL_REQ);
  assign o_wr_req     = r_valid & (r_state == stbuf_pkg::WR_L1D);

  // Bytes are already in the L1D during FINISH
  for (genvar p = 0; p < LSU_PORTS; p++) begin : g_fwd
    assign o_fwd_hit[p] = r_valid & (r_state != stbuf_pkg::FINISH) & i_fwd_valid[p] &
                          (r_body.line == i_fwd_line[p]);
  end

  // Allocator must respect the merge window and free status
  a_merge_in_window: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_merge |-> o_ready_to_merge);
  a_load_when_free: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_load |-> !r_valid);

endmodule

/* design/stbuf_l1d_arb.sv */
module stbuf_l1d_arb #(
  parameter int NUM_ENTRIES = 4
) (
  input  logic                   i_clk,
  input  logic                   i_reset_n,

  input  stbuf_pkg::st_entry_t   i_entries [NUM_ENTRIES],
  input  logic [NUM_ENTRIES-1:0] i_rd_req,
  input  logic [NUM_ENTRIES-1:0] i_refill_req,
  input  logic [NUM_ENTRIES-1:0] i_wr_req,

  input  logic                   i_l1d_rd_accepted,
  input  logic                   i_l1d_rd_hit,
  input  logic                   i_refill_accepted,
  input  logic                   i_l1d_wr_accepted,

  output logic [NUM_ENTRIES-1:0] o_rd_accepted,
  output logic [NUM_ENTRIES-1:0] o_rd_resp_vld,
  output logic                   o_rd_hit,
  output logic [NUM_ENTRIES-1:0] o_refill_accepted,
  output logic [NUM_ENTRIES-1:0] o_wr_accepted,

  output logic                   o_l1d_rd_req,
  output stbuf_pkg::line_addr_t  o_l1d_rd_line,
  output logic                   o_refill_req,
  output stbuf_pkg::line_addr_t  o_refill_line,
  output logic                   o_l1d_wr_req,
  output stbuf_pkg::st_req_t     o_l1d_wr
);

  localparam int IDX_W   = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;
  localparam int N_PORTS = 3;  // Read, refill, write

  logic [NUM_ENTRIES-1:0] w_req  [N_PORTS];
  logic [NUM_ENTRIES-1:0] w_gnt  [N_PORTS];
  logic [NUM_ENTRIES-1:0] r_lock [N_PORTS];
  logic [IDX_W-1:0]       r_ptr  [N_PORTS];
  logic [N_PORTS-1:0]     w_port_acc;
  logic [NUM_ENTRIES-1:0] r_rd_acc_oh;

  // First requester at or after the pointer
  function automatic logic [NUM_ENTRIES-1:0] rr_pick(input logic [NUM_ENTRIES-1:0] req,
                                                     input logic [IDX_W-1:0] ptr);
    logic [NUM_ENTRIES-1:0] gnt;
    int                     idx;
    gnt = '0;
    for (int k = NUM_ENTRIES - 1; k >= 0; k--) begin
      idx = (int'(ptr) + k) % NUM_ENTRIES;
      if (req[idx]) begin
        gnt      = '0;
        gnt[idx] = 1'b1;
      end
    end
    return gnt;
  endfunction

  function automatic logic [IDX_W-1:0] next_ptr(input logic [NUM_ENTRIES-1:0] oh);
    int idx;
    idx = 0;
    for (int k = 0; k < NUM_ENTRIES; k++) begin
      if (oh[k]) idx = k;
    end
    return IDX_W'((idx + 1) % NUM_ENTRIES);
  endfunction

  assign w_req[0] = i_rd_req;
  assign w_req[1] = i_refill_req;
  assign w_req[2] = i_wr_req;
  assign w_port_acc = {i_l1d_wr_accepted, i_refill_accepted, i_l1d_rd_accepted};

  // ------------------------------
  // Grant with hold until accept
  // ------------------------------
  always_comb begin
    for (int p = 0; p < N_PORTS; p++) begin
      w_gnt[p] = (|(r_lock[p] & w_req[p])) ? r_lock[p] : rr_pick(w_req[p], r_ptr[p]);
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int p = 0; p < N_PORTS; p++) begin
        r_lock[p] <= '0;
        r_ptr[p]  <= '0;
      end
      r_rd_acc_oh <= '0;
    end else begin
      for (int p = 0; p < N_PORTS; p++) begin
        if (w_port_acc[p] && (|w_gnt[p])) begin
          r_lock[p] <= '0;
          r_ptr[p]  <= next_ptr(w_gnt[p]);  // Move past the winner
        end else begin
          r_lock[p] <= w_gnt[p];
        end
      end
      r_rd_acc_oh <= o_rd_accepted;  // Response comes one cycle later
    end
  end

  // ------------------------------
  // Ports and response routing
  // ------------------------------
  assign o_rd_accepted     = w_port_acc[0] ? w_gnt[0] : '0;
  assign o_refill_accepted = w_port_acc[1] ? w_gnt[1] : '0;
  assign o_wr_accepted     = w_port_acc[2] ? w_gnt[2] : '0;
  assign o_rd_resp_vld     = r_rd_acc_oh;
  assign o_rd_hit          = i_l1d_rd_hit & (|r_rd_acc_oh);

  assign o_l1d_rd_req = |w_gnt[0];
  assign o_refill_req = |w_gnt[1];
  assign o_l1d_wr_req = |w_gnt[2];

  always_comb begin
    o_l1d_rd_line = '0;
    o_refill_line = '0;
    o_l1d_wr      = '0;
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      if (w_gnt[0][e]) o_l1d_rd_line = i_entries[e].line;
      if (w_gnt[1][e]) o_refill_line = i_entries[e].line;
      if (w_gnt[2][e]) begin
        o_l1d_wr.line = i_entries[e].line;
        o_l1d_wr.data = i_entries[e].data;
        o_l1d_wr.strb = i_entries[e].strb;
      end
    end
  end

  a_acc_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(o_rd_accepted) && $onehot0(o_refill_accepted) && $onehot0(o_wr_accepted));
  // Write payload cannot change while it waits, since merging is closed in WR_L1D
  a_wr_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_l1d_wr_req && !i_l1d_wr_accepted |=> o_l1d_wr_req && $stable(o_l1d_wr));

endmodule

/* design/stbuf_pkg.sv */
package stbuf_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int LINE_ADDR_W = 26;
  localparam int ST_BYTES    = 8;

  typedef logic [LINE_ADDR_W-1:0] line_addr_t;
  typedef logic [ST_BYTES*8-1:0]  st_data_t;
  typedef logic [ST_BYTES-1:0]    st_strb_t;

  // ------------------------------
  // Store and entry records
  // ------------------------------

  // One committed store, also the shape of an L1D write
  typedef struct packed {
    line_addr_t line;
    st_data_t   data;
    st_strb_t   strb;
  } st_req_t;

  // Register content of one entry
  typedef struct packed {
    logic       valid;
    line_addr_t line;
    st_data_t   data;
    st_strb_t   strb;
  } st_entry_t;

  // Entry life cycle
  typedef enum logic [2:0] {
    IDLE,
    RD_L1D,       // Tag read pending
    RD_RESP,      // Hit or miss comes back here
    REFILL_REQ,
    WAIT_REFILL,  // Waiting for refill done broadcast
    WR_L1D,
    FINISH
  } st_state_t;

endpackage

/* design/stbuf_top.sv */
module stbuf_top #(
  parameter int NUM_ENTRIES = 4,
  parameter int LSU_PORTS   = 2
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  // Committed stores
  input  logic                  i_st_valid,
  input  stbuf_pkg::st_req_t    i_st,
  output logic                  o_st_stall,

  // Forwarding checks
  input  logic [LSU_PORTS-1:0]  i_fwd_valid,
  input  stbuf_pkg::line_addr_t i_fwd_line [LSU_PORTS],
  output logic [LSU_PORTS-1:0]  o_fwd_hit,

  // L1D tag read
  output logic                  o_l1d_rd_req,
  output stbuf_pkg::line_addr_t o_l1d_rd_line,
  input  logic                  i_l1d_rd_accepted,
  input  logic                  i_l1d_rd_hit,

  // Refill queue
  output logic                  o_refill_req,
  output stbuf_pkg::line_addr_t o_refill_line,
  input  logic                  i_refill_accepted,
  input  logic                  i_refill_done,
  input  stbuf_pkg::line_addr_t i_refill_line,

  // L1D write
  output logic                  o_l1d_wr_req,
  output stbuf_pkg::st_req_t    o_l1d_wr,
  input  logic                  i_l1d_wr_accepted
);

  stbuf_pkg::st_entry_t   w_entries [NUM_ENTRIES];
  stbuf_pkg::st_req_t     w_st_entry;
  logic [NUM_ENTRIES-1:0] w_load, w_merge, w_ready_to_merge;
  logic [NUM_ENTRIES-1:0] w_rd_req, w_refill_req, w_wr_req;
  logic [NUM_ENTRIES-1:0] w_rd_accepted, w_rd_resp_vld, w_refill_accepted, w_wr_accepted;
  logic                   w_rd_hit;
  logic [LSU_PORTS-1:0]   w_fwd_hit [NUM_ENTRIES];

  stbuf_alloc #(.NUM_ENTRIES(NUM_ENTRIES)) u_alloc (
    .i_st_valid       (i_st_valid),
    .i_st             (i_st),
    .i_entries        (w_entries),
    .i_ready_to_merge (w_ready_to_merge),
    .o_load           (w_load),
    .o_merge          (w_merge),
    .o_st_entry       (w_st_entry),
    .o_st_stall       (o_st_stall)
  );

  for (genvar e = 0; e < NUM_ENTRIES; e++) begin : g_entry
    stbuf_entry #(.LSU_PORTS(LSU_PORTS)) u_entry (
      .i_clk             (i_clk),
      .i_reset_n         (i_reset_n),
      .i_load            (w_load[e]),
      .i_merge           (w_merge[e]),
      .i_st              (w_st_entry),
      .i_rd_accepted     (w_rd_accepted[e]),
      .i_rd_resp_vld     (w_rd_resp_vld[e]),
      .i_rd_hit          (w_rd_hit),
      .i_refill_accepted (w_refill_accepted[e]),
      .i_refill_done     (i_refill_done),
      .i_refill_line     (i_refill_line),
      .i_wr_accepted     (w_wr_accepted[e]),
      .i_fwd_valid       (i_fwd_valid),
      .i_fwd_line        (i_fwd_line),
      .o_entry           (w_entries[e]),
      .o_ready_to_merge  (w_ready_to_merge[e]),
      .o_rd_req          (w_rd_req[e]),
      .o_refill_req      (w_refill_req[e]),
      .o_wr_req          (w_wr_req[e]),
      .o_fwd_hit         (w_fwd_hit[e])
    );
  end

  stbuf_l1d_arb #(.NUM_ENTRIES(NUM_ENTRIES)) u_arb (
    .i_clk             (i_clk),
    .i_reset_n         (i_reset_n),
    .i_entries         (w_entries),
    .i_rd_req          (w_rd_req),
    .i_refill_req      (w_refill_req),
    .i_wr_req          (w_wr_req),
    .i_l1d_rd_accepted (i_l1d_rd_accepted),
    .i_l1d_rd_hit      (i_l1d_rd_hit),
    .i_refill_accepted (i_refill_accepted),
    .i_l1d_wr_accepted (i_l1d_wr_accepted),
    .o_rd_accepted     (w_rd_accepted),
    .o_rd_resp_vld     (w_rd_resp_vld),
    .o_rd_hit          (w_rd_hit),
    .o_refill_accepted (w_refill_accepted),
    .o_wr_accepted     (w_wr_accepted),
    .o_l1d_rd_req      (o_l1d_rd_req),
    .o_l1d_rd_line     (o_l1d_rd_line),
    .o_refill_req      (o_refill_req),
    .o_refill_line     (o_refill_line),
    .o_l1d_wr_req      (o_l1d_wr_req),
    .o_l1d_wr          (o_l1d_wr)
  );

  // Any entry holding the probed line
  always_comb begin
    o_fwd_hit = '0;
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      o_fwd_hit = o_fwd_hit | w_fwd_hit[e];
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the store buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module stbuf_tb -f stbuf_top.f -o stbuf_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/stbuf_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi

exit 0

/* stbuf_top.f */
design/stbuf_pkg.sv
design/stbuf_alloc.sv
design/stbuf_entry.sv
design/stbuf_l1d_arb.sv
design/stbuf_top.sv
tb/stbuf_tb.sv

/* tb/stbuf_tb.sv */
module stbuf_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_STORES = 300;
  localparam int MAX_CYCLES = 20 * NUM_STORES;  // About 20 cycles per store with the miss path
  localparam stbuf_pkg::line_addr_t LINE_BASE = 26'h1234560;

  logic                  i_clk;
  logic                  i_reset_n;
  logic                  i_st_valid;
  stbuf_pkg::st_req_t    i_st;
  logic                  o_st_stall;
  logic [1:0]            i_fwd_valid;
  stbuf_pkg::line_addr_t i_fwd_line [2];
  logic [1:0]            o_fwd_hit;
  logic                  o_l1d_rd_req;
  stbuf_pkg::line_addr_t o_l1d_rd_line;
  logic                  i_l1d_rd_accepted;
  logic                  i_l1d_rd_hit;
  logic                  o_refill_req;
  stbuf_pkg::line_addr_t o_refill_line;
  logic                  i_refill_accepted;
  logic                  i_refill_done;
  stbuf_pkg::line_addr_t i_refill_line;
  logic                  o_l1d_wr_req;
  stbuf_pkg::st_req_t    o_l1d_wr;
  logic                  i_l1d_wr_accepted;

  // L1D image and reference model indexed by the low 4 line bits
  logic [15:0] resident;
  logic [15:0] pend_valid;
  logic [7:0]  pend_strb [16];
  logic [63:0] pend_data [16];
  int          refill_idx [$];
  int          refill_due [$];
  logic        rd_resp_due;
  logic [3:0]  rd_resp_idx;
  logic        hold;          // Freezes all accepts
  int          cycle;
  int          stall_seen;
  int          stores_sent;

  stbuf_top uut (.*);

  always #5 i_clk = ~i_clk;

  function automatic stbuf_pkg::line_addr_t line_of(input logic [3:0] idx);
    return LINE_BASE + stbuf_pkg::line_addr_t'(idx);
  endfunction

  function automatic logic line_known(input stbuf_pkg::line_addr_t line);
    return line[stbuf_pkg::LINE_ADDR_W-1:4] == LINE_BASE[stbuf_pkg::LINE_ADDR_W-1:4];
  endfunction

  function automatic logic [63:0] byte_mask(input logic [7:0] strb);
    logic [63:0] m;
    for (int b = 0; b < 8; b++) begin
      m[b*8 +: 8] = {8{strb[b]}};
    end
    return m;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on first error");
  endtask

  // Retries on later cycles while the buffer stalls this line
  task automatic send_store(input logic [3:0] idx);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge i_clk);
      i_st_valid = 1'b0;
      i_st.line  = line_of(idx);
      i_st.data  = {$urandom, $urandom};
      i_st.strb  = 8'($urandom);
      #1;
      if (!o_st_stall) begin
        i_st_valid = 1'b1;
        taken      = 1'b1;
      end
    end
    stores_sent++;
  endtask

  task automatic offer_line(input logic [3:0] idx, input int cycles);
    repeat (cycles) begin
      @(negedge i_clk);
      i_st_valid = 1'b0;
      i_st.line  = line_of(idx);
    end
  endtask

  // ------------------------------
  // Checks and model update
  // ------------------------------
  always @(posedge i_clk) begin : monitor
    int   si;
    int   wi;
    int   fi;
    int   p;
    int   b;
    logic exp_hit;
    logic [63:0] mask;
    if (i_reset_n) begin
      cycle = cycle + 1;
      if (cycle >= MAX_CYCLES) begin
        stop_on_error($sformatf("Timeout: run still busy after %0d cycles", MAX_CYCLES));
      end
      for (p = 0; p < 2; p++) begin
        exp_hit = i_fwd_valid[p] && line_known(i_fwd_line[p]) &&
                  pend_valid[i_fwd_line[p][3:0]];
        assert (o_fwd_hit[p] == exp_hit)
          else stop_on_error($sformatf("ERR t=%0t o_fwd_hit[%0d] got %b exp %b",
                                       $time, p, o_fwd_hit[p], exp_hit));
      end
      si = int'(i_st.line[3:0]);
      // Four lines pending and a fifth one offered
      if ($countones(pend_valid) == 4 && line_known(i_st.line) && !pend_valid[si]) begin
        stall_seen++;
        assert (o_st_stall)
          else stop_on_error($sformatf("ERR t=%0t o_st_stall got %b exp 1", $time, o_st_stall));
      end
      if (o_refill_req) begin
        fi = int'(o_refill_line[3:0]);
        assert (line_known(o_refill_line) && !resident[fi])
          else stop_on_error($sformatf("Refill requested for line %h that is resident",
                                       o_refill_line));
        if (i_refill_accepted) begin
          refill_idx.push_back(fi);
          refill_due.push_back(cycle + 2 + int'($urandom % 5));
        end
      end
      rd_resp_due = o_l1d_rd_req && i_l1d_rd_accepted;
      rd_resp_idx = o_l1d_rd_line[3:0];
      if (o_l1d_wr_req && i_l1d_wr_accepted) begin
        wi   = int'(o_l1d_wr.line[3:0]);
        mask = byte_mask(pend_strb[wi]);
        assert (line_known(o_l1d_wr.line) && pend_valid[wi])
          else stop_on_error($sformatf("Write accepted for line %h with no pending stores",
                                       o_l1d_wr.line));
        assert (resident[wi])
          else stop_on_error($sformatf("Write accepted for line %h that is not resident",
                                       o_l1d_wr.line));
        assert (o_l1d_wr.strb == pend_strb[wi])
          else stop_on_error($sformatf("ERR t=%0t o_l1d_wr.strb got %h exp %h",
                                       $time, o_l1d_wr.strb, pend_strb[wi]));
        assert ((o_l1d_wr.data & mask) == (pend_data[wi] & mask))
          else stop_on_error($sformatf("ERR t=%0t o_l1d_wr.data got %h exp %h",
                                       $time, o_l1d_wr.data & mask, pend_data[wi] & mask));
        pend_valid[wi] = 1'b0;
        pend_strb[wi]  = '0;
      end
      if (i_st_valid && !o_st_stall) begin
        for (b = 0; b < 8; b++) begin
          if (i_st.strb[b]) pend_data[si][b*8 +: 8] = i_st.data[b*8 +: 8];  // Later byte wins
        end
        pend_strb[si]  = pend_strb[si] | i_st.strb;
        pend_valid[si] = 1'b1;
      end
    end
  end

  // ------------------------------
  // L1D, refill queue and probes
  // ------------------------------
  always @(negedge i_clk) begin : l1d_model
    int k;
    int done_k;
    if (cycle > 0) begin
      i_l1d_rd_accepted = !hold && o_l1d_rd_req && ($urandom % 4 != 0);
      i_refill_accepted = !hold && o_refill_req && ($urandom % 2 == 0);
      i_l1d_wr_accepted = !hold && o_l1d_wr_req && ($urandom % 3 != 0);
      i_l1d_rd_hit = rd_resp_due ? resident[rd_resp_idx] : 1'($urandom);
      done_k = -1;
      for (k = 0; k < refill_idx.size(); k++) begin
        if (done_k < 0 && refill_due[k] <= cycle) done_k = k;
      end
      i_refill_done = (done_k >= 0);
      if (done_k >= 0) begin
        i_refill_line = line_of(4'(refill_idx[done_k]));
        resident[refill_idx[done_k]] = 1'b1;
        refill_idx.delete(done_k);
        refill_due.delete(done_k);
      end else begin
        i_refill_line = line_of(4'($urandom));  // Ignored without done
      end
      for (k = 0; k < 2; k++) begin
        i_fwd_valid[k] = ($urandom % 4 != 0);
        i_fwd_line[k]  = line_of(4'($urandom));
        if ($urandom % 8 == 0) i_fwd_line[k][20] = ~i_fwd_line[k][20];  // Outside the set
      end
    end
  end

  initial begin : stimulus
    int n;
    void'($urandom(61));
    i_clk             = 1'b0;
    i_reset_n         = 1'b0;
    i_st_valid        = 1'b0;
    i_st              = '0;
    i_fwd_valid       = '0;
    i_fwd_line[0]     = '0;
    i_fwd_line[1]     = '0;
    i_l1d_rd_accepted = 1'b0;
    i_l1d_rd_hit      = 1'b0;
    i_refill_accepted = 1'b0;
    i_refill_done     = 1'b0;
    i_refill_line     = '0;
    i_l1d_wr_accepted = 1'b0;
    resident    = '0;
    pend_valid  = '0;
    rd_resp_due = 1'b0;
    rd_resp_idx = '0;
    hold        = 1'b0;
    cycle       = 0;
    stall_seen  = 0;
    stores_sent = 0;
    for (n = 0; n < 16; n++) begin
      pend_strb[n] = '0;
      pend_data[n] = '0;
    end

    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    #1;
    assert (!o_st_stall && !o_l1d_rd_req && !o_refill_req && !o_l1d_wr_req && o_fwd_hit == 0)
      else stop_on_error("Stall or request outputs not low after reset");

    // Fill all four entries while reads are held off
    hold = 1'b1;
    for (n = 0; n < 4; n++) begin
      send_store(4'(n));
    end
    send_store(4'd2);
    offer_line(4'd4, 3);
    @(posedge i_clk);
    hold = 1'b0;

    while (stores_sent < NUM_STORES) begin
      if ($urandom % 4 == 0) offer_line(4'($urandom), 1);
      else send_store(4'($urandom));
    end
    offer_line(4'd0, 1);

    // Quiet for a few cycles in a row so a pending replay is not missed
    n = 0;
    while (n < 3) begin
      @(negedge i_clk);
      #2;
      if (o_l1d_rd_req || o_refill_req || o_l1d_wr_req || rd_resp_due ||
          refill_idx.size() != 0) n = 0;
      else n++;
    end

    if (pend_valid == '0 && stall_seen > 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      stop_on_error($sformatf("End of run with pending lines %b and %0d full-buffer probes",
                              pend_valid, stall_seen));
    end
  end

endmodule
